// ==== filelist.f ====
+incdir+bench
source/frontend_pkg.sv
source/fetch_pc_reg.sv
source/btb.sv
source/npu.sv
source/branch_resolve.sv
source/frontend_top.sv
bench/tb_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ns \
    -f filelist.f --top-module tb_frontend -o sim_frontend

./obj_dir/sim_frontend > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi

// ==== bench/frontend_model.svh ====
`ifndef FRONTEND_MODEL_SVH
`define FRONTEND_MODEL_SVH

// Reference model of the fetch front end
// It keeps its own fetch PC and its own copy of the BTB entries
// The enclosing testbench declares model_entries and model_idx_bits

logic [31:0] m_pc;
logic        m_valid  [model_entries];
logic [31:0] m_tag    [model_entries];
logic [31:0] m_target [model_entries];
logic [1:0]  m_ctr    [model_entries];

// Boot vector and an empty BTB
function automatic void reset_model(input logic [31:0] boot_addr);
    m_pc = boot_addr;
    for (int i = 0; i < model_entries; i++) begin
        m_valid[i]  = 1'b0;
        m_tag[i]    = 32'h0;
        m_target[i] = 32'h0;
        m_ctr[i]    = 2'b00;
    end
endfunction

// The index is the PC slice right above the two byte offset bits
function automatic int btb_index(input logic [31:0] pc);
    return int'(pc[2 +: model_idx_bits]);
endfunction

// Everything above the index is the tag
function automatic logic [31:0] btb_tag(input logic [31:0] pc);
    return pc >> (2 + model_idx_bits);
endfunction

// A prediction needs a matching valid entry in the taken half of the counter range
function automatic logic predict_taken(input logic [31:0] pc);
    int i;
    i = btb_index(pc);
    return m_valid[i] && (m_tag[i] == btb_tag(pc)) && (m_ctr[i] >= ctr_taken_min);
endfunction

// The target output reads as zero whenever there is no prediction
function automatic logic [31:0] predicted_target(input logic [31:0] pc);
    return predict_taken(pc) ? m_target[btb_index(pc)] : 32'h0;
endfunction

// Wrong direction, or taken with a wrong target
function automatic logic expect_flush(input logic valid, input logic taken,
                                      input logic [31:0] target, input logic predicted,
                                      input logic [31:0] pred_tgt);
    return valid && ((predicted != taken) || (taken && (pred_tgt != target)));
endfunction

// One clock edge of the front end, fed with the inputs of the cycle that ends
function automatic void advance_model(input logic stall, input logic valid,
                                      input logic [31:0] pc, input logic taken,
                                      input logic [31:0] target, input logic predicted,
                                      input logic [31:0] pred_tgt);
    logic [31:0] next_pc;
    logic        redirect;
    logic        hit;
    int          i;
    redirect = expect_flush(valid, taken, target, predicted, pred_tgt);
    // The next address is chosen from the BTB contents before this edge trains it
    if (redirect) begin
        next_pc = taken ? target : pc + 32'(pc_step);
    end else if (predict_taken(m_pc)) begin
        next_pc = predicted_target(m_pc);
    end else begin
        next_pc = m_pc + 32'(pc_step);
    end
    if (redirect || !stall) begin
        m_pc = next_pc;
    end
    if (valid) begin
        i   = btb_index(pc);
        hit = m_valid[i] && (m_tag[i] == btb_tag(pc));
        if (hit) begin
            // Saturating two bit counter, and a taken outcome refreshes the target
            if (taken && (m_ctr[i] != 2'b11)) begin
                m_ctr[i] = m_ctr[i] + 2'b01;
            end else if (!taken && (m_ctr[i] != 2'b00)) begin
                m_ctr[i] = m_ctr[i] - 2'b01;
            end
            m_target[i] = taken ? target : m_target[i];
        end else if (taken) begin
            m_valid[i]  = 1'b1;
            m_tag[i]    = btb_tag(pc);
            m_target[i] = target;
            m_ctr[i]    = ctr_weak_taken;
        end
    end
endfunction

`endif

// ==== bench/tb_frontend.sv ====
`timescale 1ns/1ns

module tb_frontend;

    import frontend_pkg::*;

    localparam int          model_entries  = 16;
    localparam int          model_idx_bits = 4;
    localparam logic [31:0] boot_pc        = 32'h0000_0100;

    // Bit i of outcome_trace is the outcome of resolve i after allocation
    // Bits 2i+1 and 2i of ctr_trace hold the counter expected after that resolve
    localparam logic [9:0]  outcome_trace = 10'b0111000011;
    localparam logic [19:0] ctr_trace     = 20'b10_11_10_01_00_00_01_10_11_11;

    `include "frontend_model.svh"

    logic        clk;
    logic        arst_n;
    logic        fetch_stall;
    logic        ex_valid;
    logic [31:0] ex_pc;
    logic        ex_taken;
    logic [31:0] ex_target;
    logic        ex_predicted;
    logic [31:0] ex_pred_target;
    logic [31:0] pc_fetch;
    logic        branch_predicted;
    logic [31:0] pred_target;
    logic        flush;

    int check_count = 0;
    int error_count = 0;
    int test_errors = 0;
    int test_count  = 0;

    frontend_top #(.xlen(32), .btb_entries(model_entries), .reset_pc(boot_pc)) dut0 (
        .clk(clk), .arst_n(arst_n), .fetch_stall(fetch_stall), .ex_valid(ex_valid),
        .ex_pc(ex_pc), .ex_taken(ex_taken), .ex_target(ex_target),
        .ex_predicted(ex_predicted), .ex_pred_target(ex_pred_target),
        .pc_fetch(pc_fetch), .branch_predicted(branch_predicted),
        .pred_target(pred_target), .flush(flush)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, actual, expected);
            error_count++;
            test_errors++;
        end
    endtask

    // Outputs are compared at the falling edge when the inputs have long settled
    task automatic compare_outputs();
        check_value("pc_fetch", pc_fetch, m_pc);
        check_value("branch_predicted", 32'(branch_predicted), 32'(predict_taken(m_pc)));
        check_value("pred_target", pred_target, predicted_target(m_pc));
        check_value("flush", 32'(flush), 32'(expect_flush(ex_valid, ex_taken, ex_target,
                                                           ex_predicted, ex_pred_target)));
    endtask

    // Drive one cycle, check it against the model, then step the model over the next edge
    task automatic run_cycle(input logic stall, input logic valid, input logic [31:0] pc,
                             input logic taken, input logic [31:0] target,
                             input logic predicted, input logic [31:0] pred_tgt);
        @(posedge clk);
        fetch_stall    <= stall;
        ex_valid       <= valid;
        ex_pc          <= pc;
        ex_taken       <= taken;
        ex_target      <= target;
        ex_predicted   <= predicted;
        ex_pred_target <= pred_tgt;
        @(negedge clk);
        compare_outputs();
        advance_model(stall, valid, pc, taken, target, predicted, pred_tgt);
    endtask

    task automatic idle_cycle(input logic stall);
        run_cycle(stall, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0);
    endtask

    task automatic wait_for_pc(input logic [31:0] addr, input int limit);
        int n;
        n = 0;
        while ((pc_fetch != addr) && (n < limit)) begin
            idle_cycle(1'b0);
            n++;
        end
        if (pc_fetch != addr) begin
            $display("Timeout: fetch PC did not reach %h within %0d cycles", addr, limit);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("Test %-16s done, %0d mismatches", name, test_errors);
        test_count++;
        test_errors = 0;
    endtask

    initial begin
        int unsigned seed_dummy;
        logic [31:0] exp_pc;
        logic [1:0]  exp_ctr;
        logic        o;
        logic [31:0] r_pc;
        logic [31:0] r_tgt;
        seed_dummy = $urandom(8380);
        arst_n         <= 1'b0;
        fetch_stall    <= 1'b0;
        ex_valid       <= 1'b0;
        ex_pc          <= 32'h0;
        ex_taken       <= 1'b0;
        ex_target      <= 32'h0;
        ex_predicted   <= 1'b0;
        ex_pred_target <= 32'h0;
        reset_model(boot_pc);
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        // Reset state with all inputs idle
        @(negedge clk);
        compare_outputs();
        check_value("pc_fetch", pc_fetch, boot_pc);
        check_value("flush", 32'(flush), 32'h0);
        check_value("branch_predicted", 32'(branch_predicted), 32'h0);
        advance_model(1'b0, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 32'h0);
        finish_test("reset");

        // Empty BTB, so fetch walks forward and freezes under stall
        exp_pc = m_pc;
        for (int i = 0; i < 6; i++) begin
            idle_cycle(1'b0);
            check_value("pc_fetch", pc_fetch, exp_pc);
            exp_pc = exp_pc + 32'(pc_step);
        end
        for (int i = 0; i < 4; i++) begin
            idle_cycle(1'b1);
            check_value("pc_fetch", pc_fetch, exp_pc);
        end
        for (int i = 0; i < 2; i++) begin
            idle_cycle(1'b0);
            check_value("pc_fetch", pc_fetch, exp_pc);
            exp_pc = exp_pc + 32'(pc_step);
        end
        finish_test("sequential_stall");

        // Train 0x200 as taken, then steer fetch there with a not-taken flush from 0x1fc
        run_cycle(1'b0, 1'b1, 32'h200, 1'b1, 32'h400, 1'b1, 32'h400);
        run_cycle(1'b0, 1'b1, 32'h1fc, 1'b0, 32'h0, 1'b1, 32'h0);
        wait_for_pc(32'h200, 8);
        check_value("branch_predicted", 32'(branch_predicted), 32'h1);
        check_value("pred_target", pred_target, 32'h400);
        idle_cycle(1'b0);
        check_value("pc_fetch", pc_fetch, 32'h400);
        finish_test("learning");

        // Every resolve here comes under stall and a flush still has to move the PC
        run_cycle(1'b1, 1'b1, 32'h300, 1'b1, 32'h480, 1'b1, 32'h490);
        check_value("flush", 32'(flush), 32'h1);
        idle_cycle(1'b1);
        check_value("pc_fetch", pc_fetch, 32'h480);
        run_cycle(1'b1, 1'b1, 32'h340, 1'b0, 32'h0, 1'b1, 32'h0);
        check_value("flush", 32'(flush), 32'h1);
        idle_cycle(1'b1);
        check_value("pc_fetch", pc_fetch, 32'h344);
        run_cycle(1'b1, 1'b1, 32'h380, 1'b1, 32'h600, 1'b0, 32'h0);
        check_value("flush", 32'(flush), 32'h1);
        idle_cycle(1'b1);
        check_value("pc_fetch", pc_fetch, 32'h600);
        // A correct prediction leaves the held PC alone
        run_cycle(1'b1, 1'b1, 32'h3c0, 1'b0, 32'h0, 1'b0, 32'h0);
        check_value("flush", 32'(flush), 32'h0);
        idle_cycle(1'b1);
        check_value("pc_fetch", pc_fetch, 32'h600);
        finish_test("mispredict");

        // Park fetch on 0xa00, which shares index 0 with the earlier entries
        run_cycle(1'b1, 1'b1, 32'h9fc, 1'b0, 32'h0, 1'b1, 32'h0);
        idle_cycle(1'b1);
        check_value("pc_fetch", pc_fetch, 32'ha00);
        run_cycle(1'b1, 1'b1, 32'ha00, 1'b1, 32'hc00, 1'b1, 32'hc00);
        idle_cycle(1'b1);
        check_value("branch_predicted", 32'(branch_predicted), 32'h1);
        // Resolves agree with their own direction so nothing flushes the parked PC
        for (int i = 0; i < 10; i++) begin
            o       = outcome_trace[i];
            exp_ctr = ctr_trace[2*i +: 2];
            r_tgt   = o ? 32'hc00 : 32'h0;
            run_cycle(1'b1, 1'b1, 32'ha00, o, r_tgt, o, r_tgt);
            idle_cycle(1'b1);
            check_value("branch_predicted", 32'(branch_predicted), 32'(exp_ctr >= 2'b10));
        end
        finish_test("hysteresis");

        // Four tags on four indices keep evicting each other
        for (int i = 0; i < 2000; i++) begin
            r_pc  = 32'h1000 | (($urandom % 4) << 6) | (($urandom % 4) << 2);
            r_pc  = (($urandom % 4) == 0) ? m_pc : r_pc;
            r_tgt = 32'h1000 | (($urandom % 64) << 2);
            run_cycle(($urandom % 4) == 0, ($urandom % 5) < 2, r_pc, ($urandom % 2) == 1,
                      r_tgt, ($urandom % 2) == 1,
                      (($urandom % 2) == 1) ? r_tgt : 32'h1000 | (($urandom % 64) << 2));
        end
        finish_test("random");

        $display("Summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
                 error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== source/frontend_top.sv ====
`timescale 1ns/1ns

// Fetch front end
// PC register, BTB lookup, next-PC selection and branch resolve
module frontend_top #(
    parameter int              xlen        = 32,
    parameter int              btb_entries = 16,
    parameter logic [xlen-1:0] reset_pc    = 32'h0000_0100
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            fetch_stall,
    input  logic            ex_valid,
    input  logic [xlen-1:0] ex_pc,
    input  logic            ex_taken,
    input  logic [xlen-1:0] ex_target,
    input  logic            ex_predicted,
    input  logic [xlen-1:0] ex_pred_target,
    output logic [xlen-1:0] pc_fetch,
    output logic            branch_predicted,
    output logic [xlen-1:0] pred_target,
    output logic            flush
);

    logic [xlen-1:0] pc_next;
    logic            branch_en;
    logic [xlen-1:0] pc_target;
    logic [xlen-1:0] redirect_pc;
    logic            upd_en;
    logic [xlen-1:0] upd_pc;
    logic            upd_taken;
    logic [xlen-1:0] upd_target;

    // Architectural fetch counter
    fetch_pc_reg #(.xlen(xlen), .reset_pc(reset_pc)) u_fetch_pc (
        .clk         (clk),
        .arst_n      (arst_n),
        .fetch_stall (fetch_stall),
        .flush       (flush),
        .pc_next     (pc_next),
        .pc_fetch    (pc_fetch)
    );

    // Lookup uses the current fetch PC and training comes from the resolve block
    btb #(.xlen(xlen), .btb_entries(btb_entries)) u_btb (
        .clk        (clk),
        .arst_n     (arst_n),
        .pc_fetch   (pc_fetch),
        .branch_en  (branch_en),
        .pc_target  (pc_target),
        .upd_en     (upd_en),
        .upd_pc     (upd_pc),
        .upd_taken  (upd_taken),
        .upd_target (upd_target)
    );

    npu #(.xlen(xlen)) u_npu (
        .pc_fetch         (pc_fetch),
        .flush            (flush),
        .redirect_pc      (redirect_pc),
        .branch_en        (branch_en),
        .pc_target        (pc_target),
        .pc_next          (pc_next),
        .branch_predicted (branch_predicted)
    );

    // Plays the role of the back end check on the execute stage result
    branch_resolve #(.xlen(xlen)) u_resolve (
        .ex_valid       (ex_valid),
        .ex_pc          (ex_pc),
        .ex_taken       (ex_taken),
        .ex_target      (ex_target),
        .ex_predicted   (ex_predicted),
        .ex_pred_target (ex_pred_target),
        .flush          (flush),
        .redirect_pc    (redirect_pc),
        .upd_en         (upd_en),
        .upd_pc         (upd_pc),
        .upd_taken      (upd_taken),
        .upd_target     (upd_target)
    );

    // The predicted target leaves with the fetch so it can be checked later
    assign pred_target = pc_target;

endmodule

// ==== source/branch_resolve.sv ====
`timescale 1ns/1ns

// Branch resolve block
// Checks a branch reported by execute against what fetch predicted for it
// and produces the redirect and the BTB training write
module branch_resolve #(
    parameter int xlen = 32
) (
    input  logic            ex_valid,
    input  logic [xlen-1:0] ex_pc,
    input  logic            ex_taken,
    input  logic [xlen-1:0] ex_target,
    input  logic            ex_predicted,
    input  logic [xlen-1:0] ex_pred_target,
    output logic            flush,
    output logic [xlen-1:0] redirect_pc,
    output logic            upd_en,
    output logic [xlen-1:0] upd_pc,
    output logic            upd_taken,
    output logic [xlen-1:0] upd_target
);

    import frontend_pkg::*;

    logic            dir_wrong;
    logic            tgt_wrong;
    logic            mispredict;
    logic [xlen-1:0] ex_pc_seq;

    // Direction check
    // Fetch went one way and the branch went the other
    always_comb begin
        dir_wrong = (ex_predicted != ex_taken);
    end

    // Target check
    // Only matters for a taken branch that fetch also guessed taken
    // For a predicted not-taken branch the direction check already fires
    always_comb begin
        tgt_wrong = ex_taken && (ex_pred_target != ex_target);
    end

    always_comb begin
        mispredict = dir_wrong || tgt_wrong;
    end

    // Flush is a single-cycle strobe tied to the resolve strobe
    always_comb begin
        flush = ex_valid && mispredict;
    end

    // Correct continuation point of the program after the branch
    always_comb begin
        ex_pc_seq = ex_pc + xlen'(pc_step);
        if (ex_taken) begin
            redirect_pc = ex_target;
        end else begin
            redirect_pc = ex_pc_seq;
        end
    end

    // Training request
    // Every resolved branch trains the BTB whether it was right or not
    // so the counters keep following the actual behaviour
    always_comb begin
        upd_en     = ex_valid;
        upd_pc     = ex_pc;
        upd_taken  = ex_taken;
        upd_target = ex_target;
    end

endmodule

// ==== source/npu.sv ====
`timescale 1ns/1ns

// Next-PC unit
// Picks the address that the fetch counter loads on the next edge
module npu #(
    parameter int xlen = 32
) (
    input  logic [xlen-1:0] pc_fetch,
    input  logic            flush,
    input  logic [xlen-1:0] redirect_pc,
    input  logic            branch_en,
    input  logic [xlen-1:0] pc_target,
    output logic [xlen-1:0] pc_next,
    output logic            branch_predicted
);

    import frontend_pkg::*;

    logic [xlen-1:0] pc_seq;
    logic [xlen-1:0] pc_pred;

    // Fall-through address of the instruction being fetched
    always_comb begin
        pc_seq = pc_fetch + xlen'(pc_step);
    end

    // First level of selection
    // A BTB hit with a taken counter steers fetch to the stored target
    // Otherwise fetch just walks forward
    always_comb begin
        if (branch_en) begin
            pc_pred = pc_target;
        end else begin
            pc_pred = pc_seq;
        end
    end

    // Second level of selection
    // A flush from the resolve block wins over any prediction
    // since everything fetched after the bad branch gets thrown away
    always_comb begin
        if (flush) begin
            pc_next = redirect_pc;
        end else begin
            pc_next = pc_pred;
        end
    end

    // The prediction bit goes down the pipeline with the instruction
    // and is checked against the real outcome in execute
    always_comb begin
        branch_predicted = branch_en;
    end

endmodule

// ==== source/btb.sv ====
`timescale 1ns/1ns

// Direct-mapped branch target buffer
// Each entry holds a valid bit, a tag, a target and a 2-bit counter
module btb #(
    parameter int xlen        = 32,
    parameter int btb_entries = 16
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic [xlen-1:0] pc_fetch,
    output logic            branch_en,
    output logic [xlen-1:0] pc_target,
    input  logic            upd_en,
    input  logic [xlen-1:0] upd_pc,
    input  logic            upd_taken,
    input  logic [xlen-1:0] upd_target
);

    import frontend_pkg::*;

    // Instructions are word aligned so the two low PC bits carry no information
    // The index sits right above them and the tag takes the rest
    localparam int idx_width = $clog2(btb_entries);
    localparam int idx_lsb   = 2;
    localparam int tag_lsb   = idx_lsb + idx_width;
    localparam int tag_width = xlen - tag_lsb;

    logic                 valid_q  [btb_entries];
    logic [tag_width-1:0] tag_q    [btb_entries];
    logic [xlen-1:0]      target_q [btb_entries];
    logic [ctr_width-1:0] ctr_q    [btb_entries];

    logic [idx_width-1:0] rd_idx;
    logic [tag_width-1:0] rd_tag;
    logic                 rd_hit;

    logic [idx_width-1:0] wr_idx;
    logic [tag_width-1:0] wr_tag;
    logic                 wr_hit;
    logic [ctr_width-1:0] wr_ctr_old;
    logic [ctr_width-1:0] wr_ctr_new;

    // Lookup side
    // A hit needs a valid entry whose stored tag matches the fetch PC
    always_comb begin
        rd_idx    = pc_fetch[idx_lsb +: idx_width];
        rd_tag    = pc_fetch[tag_lsb +: tag_width];
        rd_hit    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
        // Only a counter in the taken half turns a hit into a prediction
        branch_en = rd_hit && (ctr_q[rd_idx] >= ctr_taken_min);
        // The target is only meaningful when a prediction is made
        pc_target = branch_en ? target_q[rd_idx] : '0;
    end

    // Training side
    // Same index and tag split applied to the PC of the resolved branch
    always_comb begin
        wr_idx     = upd_pc[idx_lsb +: idx_width];
        wr_tag     = upd_pc[tag_lsb +: tag_width];
        wr_hit     = valid_q[wr_idx] && (wr_tag == tag_q[wr_idx]);
        wr_ctr_old = ctr_q[wr_idx];
        wr_ctr_new = wr_ctr_old;
        // Saturating step toward the actual outcome
        if (upd_taken && (wr_ctr_old != ctr_max)) begin
            wr_ctr_new = wr_ctr_old + 1'b1;
        end else if (!upd_taken && (wr_ctr_old != ctr_min)) begin
            wr_ctr_new = wr_ctr_old - 1'b1;
        end
    end

    // Valid bits are the only control state here
    // A taken branch that misses claims the slot and evicts any older tag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < btb_entries; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (upd_en && !wr_hit && upd_taken) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Entry payload
    // On a hit the counter moves and a taken branch refreshes the target
    // On a miss only a taken branch allocates and not-taken misses are dropped
    always_ff @(posedge clk) begin
        if (upd_en) begin
            if (wr_hit) begin
                ctr_q[wr_idx] <= wr_ctr_new;
                if (upd_taken) begin
                    target_q[wr_idx] <= upd_target;
                end
            end else if (upd_taken) begin
                tag_q[wr_idx]    <= wr_tag;
                target_q[wr_idx] <= upd_target;
                ctr_q[wr_idx]    <= ctr_weak_taken;
            end
        end
    end

endmodule

// ==== source/fetch_pc_reg.sv ====
`timescale 1ns/1ns

// Architectural fetch program counter
// Holds the address that the front end is fetching in the current cycle
module fetch_pc_reg #(
    parameter int              xlen     = 32,
    parameter logic [xlen-1:0] reset_pc = '0
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            fetch_stall,
    input  logic            flush,
    input  logic [xlen-1:0] pc_next,
    output logic [xlen-1:0] pc_fetch
);

    // Load enable for the counter
    // A stall freezes the PC but a flush must always get through
    // because the instruction stream behind the stall is wrong anyway
    logic pc_load;

    always_comb begin
        pc_load = flush || !fetch_stall;
    end

    // The counter comes out of reset at the boot vector
    // After that it follows whatever the next-PC unit selects
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_fetch <= reset_pc;
        end else if (pc_load) begin
            pc_fetch <= pc_next;
        end
    end

    // Note on timing
    // pc_next is purely combinational from pc_fetch and the resolve strobe
    // so a redirect raised in cycle n is the fetch address in cycle n+1

    // Held PC during a stall keeps the same BTB lookup on the output
    // which keeps branch_predicted and pred_target stable as well
    // The BTB itself can still be trained while the PC is frozen
    // so the prediction for a held PC may change from one cycle to the next

endmodule

// ==== source/frontend_pkg.sv ====
package frontend_pkg;

    // Size of one instruction in bytes
    // The sequential fetch path adds this to the current PC
    localparam int unsigned pc_step = 4;

    // Every BTB entry keeps a small saturating counter of this many bits
    localparam int unsigned ctr_width = 2;

    // Counter encoding
    // 00 strongly not taken
    // 01 weakly not taken
    // 10 weakly taken
    // 11 strongly taken

    // A freshly allocated entry starts one step into the taken half
    // A single not-taken outcome then drops it to a not-taken prediction
    localparam logic [ctr_width-1:0] ctr_weak_taken = 2'b10;

    // Counters at or above this value predict taken
    localparam logic [ctr_width-1:0] ctr_taken_min = 2'b10;

    // Saturation limits of the counter
    localparam logic [ctr_width-1:0] ctr_max = '1;
    localparam logic [ctr_width-1:0] ctr_min = '0;

endpackage
